// ==== build.f ====
src/operand_pkg.sv
src/root_pkg.sv
src/magnitude_decode.sv
src/isqrt_step.sv
src/magnitude_execute.sv
src/magnitude_result.sv
src/tt_um_addon.sv
verification/mag_asserts.sv
verification/mag_checker.sv
verification/tb_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the magnitude testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --timescale 1ns/1ps \
    --top-module tb_top \
    -f build.f \
    -o Vtb_top

output=$(./obj_dir/Vtb_top)
printf '%s\n' "$output"

if printf '%s\n' "$output" | grep -q "Test completed successfully"; then
    exit 0
fi
exit 1

// ==== src/isqrt_step.sv ====
module isqrt_step #(
    parameter int BIT = 0                       // Root bit decided here
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  ena,
    input  root_pkg::root_stage_t stage_in,     // From previous step
    output root_pkg::root_stage_t stage_out     // To next step
);

    logic [root_pkg::ROOT_W-1:0]   trial;       // Incoming root with BIT set
    logic [2*root_pkg::ROOT_W-1:0] trial_sq;    // Up to 511^2, 18 bits
    logic                          fits;        // Trial still below radicand
    root_pkg::root_stage_t         stage_next;

    // Restoring step
    // Lower bits are still zero so trial^2 is exact
    always_comb begin
        trial      = stage_in.root;
        trial[BIT] = 1'b1;
    end

    assign trial_sq = trial * trial;
    assign fits     = (trial_sq <= {1'b0, stage_in.radicand});

    always_comb begin
        stage_next.radicand = stage_in.radicand;             // Passed along as is
        stage_next.root     = fits ? trial : stage_in.root;  // Keep or drop the bit
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            stage_out <= '0;
        end else if (ena) begin
            stage_out <= stage_next;
        end
    end

endmodule

// ==== src/magnitude_decode.sv ====
module magnitude_decode (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      ena,      // Pipeline advance
    input  operand_pkg::coord_t       x,        // From ui_in
    input  operand_pkg::coord_t       y,        // From uio_in
    output operand_pkg::square_pair_t squares   // To execute
);

    operand_pkg::square_pair_t squares_next;   // Unregistered products

    // Two independent 8x8 multipliers
    always_comb begin
        squares_next.sq_x = operand_pkg::square(x);
        squares_next.sq_y = operand_pkg::square(y);
    end

    // First pipeline stage
    // Holds while ena is low
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            squares <= '0;                     // Zero vector after reset
        end else if (ena) begin
            squares <= squares_next;
        end
    end

endmodule

// ==== src/magnitude_execute.sv ====
module magnitude_execute (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      ena,
    input  operand_pkg::square_pair_t squares,   // From decode
    output root_pkg::root_stage_t     root_out   // Finished root, to result
);

    logic [root_pkg::RAD_W-1:0] sum_next;        // x^2 + y^2, one carry bit extra

    // stage[0] is the sum register
    // stage[i+1] is the output of step i
    root_pkg::root_stage_t stage [0:root_pkg::ROOT_W];

    // 16 + 16 bits into 17, no overflow possible
    assign sum_next = {1'b0, squares.sq_x} + {1'b0, squares.sq_y};

    // Sum stage
    // Root starts at zero and is built up MSB first
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            stage[0] <= '0;
        end else if (ena) begin
            stage[0].radicand <= sum_next;
            stage[0].root     <= '0;
        end
    end

    // Nine root steps, bit 8 down to bit 0
    // One vector per stage while the chain is full
    for (genvar i = 0; i < root_pkg::ROOT_W; i++) begin : g_step
        isqrt_step #(
            .BIT (root_pkg::ROOT_W - 1 - i)
        ) u_step (
            .clk       (clk),
            .rst_n     (rst_n),
            .ena       (ena),
            .stage_in  (stage[i]),
            .stage_out (stage[i+1])
        );
    end

    assign root_out = stage[root_pkg::ROOT_W];  // Already registered in last step

endmodule

// ==== src/magnitude_result.sv ====
module magnitude_result (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        ena,
    input  root_pkg::root_stage_t       root_in,    // Last step of execute
    output logic [root_pkg::OUT_W-1:0]  magnitude,  // Saturated root
    output logic                        overflow    // Root above 255
);

    logic                       over_next;
    logic [root_pkg::OUT_W-1:0] mag_next;

    // Any bit above the output width means the root does not fit
    assign over_next = |root_in.root[root_pkg::ROOT_W-1:root_pkg::OUT_W];

    // Clamp to all ones on overflow
    assign mag_next = over_next ? {root_pkg::OUT_W{1'b1}}
                                : root_in.root[root_pkg::OUT_W-1:0];

    // Output register, drives the pins directly
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            magnitude <= '0;
            overflow  <= 1'b0;
        end else if (ena) begin
            magnitude <= mag_next;
            overflow  <= over_next;
        end
    end

endmodule

// ==== src/operand_pkg.sv ====
package operand_pkg;

    // Input side of the magnitude pipeline
    localparam int COORD_W = 8;            // One pin bus per coordinate
    localparam int SQ_W    = 2 * COORD_W;  // Full product, no truncation

    // Raw coordinate as sampled from ui_in / uio_in
    typedef logic [COORD_W-1:0] coord_t;

    // Registered squares handed from decode to execute
    typedef struct packed {
        logic [SQ_W-1:0] sq_x;  // x * x
        logic [SQ_W-1:0] sq_y;  // y * y
    } square_pair_t;

    // Unsigned square of one coordinate
    // 255 * 255 = 65025 still fits in SQ_W bits
    function automatic logic [SQ_W-1:0] square(input coord_t value);
        logic [SQ_W-1:0] wide;  // Operand widened before the multiply
        wide = {{(SQ_W - COORD_W){1'b0}}, value};
        return wide * wide;     // Upper half of the product is always zero
    endfunction

endpackage

// ==== src/root_pkg.sv ====
package root_pkg;

    // Root side of the magnitude pipeline
    localparam int RAD_W  = 17;  // Holds 2 * 255^2 = 130050
    localparam int ROOT_W = 9;   // sqrt(130050) = 360, needs 9 bits
    localparam int OUT_W  = 8;   // Width of uo_out

    // Record passed down the root chain
    // Radicand rides along unchanged so every stage holds its own vector
    typedef struct packed {
        logic [RAD_W-1:0]  radicand;  // x^2 + y^2
        logic [ROOT_W-1:0] root;      // Root bits decided so far
    } root_stage_t;

endpackage

// ==== src/tt_um_addon.sv ====
module tt_um_addon (
    input  operand_pkg::coord_t        ui_in,    // x
    input  operand_pkg::coord_t        uio_in,   // y
    output logic [root_pkg::OUT_W-1:0] uo_out,   // Saturated magnitude
    output logic [7:0]                 uio_out,  // Bit 0 is overflow
    output logic [7:0]                 uio_oe,   // Only bit 0 driven
    input  logic                       ena,      // Global advance
    input  logic                       clk,
    input  logic                       rst_n
);

    operand_pkg::square_pair_t squares;    // Decode to execute
    root_pkg::root_stage_t     root_last;  // Execute to result
    logic                      overflow;

    // 1 cycle, registered squares
    magnitude_decode u_decode (
        .clk     (clk),
        .rst_n   (rst_n),
        .ena     (ena),
        .x       (ui_in),
        .y       (uio_in),
        .squares (squares)
    );

    // 10 cycles, sum plus nine root steps
    magnitude_execute u_execute (
        .clk      (clk),
        .rst_n    (rst_n),
        .ena      (ena),
        .squares  (squares),
        .root_out (root_last)
    );

    // 1 cycle, saturation and pin register
    magnitude_result u_result (
        .clk       (clk),
        .rst_n     (rst_n),
        .ena       (ena),
        .root_in   (root_last),
        .magnitude (uo_out),
        .overflow  (overflow)
    );

    assign uio_out = {7'b0, overflow};  // Upper bidir pins stay low
    assign uio_oe  = 8'b0000_0001;      // Rest of uio stays input

endmodule

// ==== verification/mag_asserts.sv ====
module mag_asserts (
    input logic       clk,
    input logic       rst_n,
    input logic       ena,
    input logic [7:0] magnitude,
    input logic       overflow
);
    timeunit 1ns;
    timeprecision 1ps;

    int fail_count = 0;  // Failed assertions so far

    // Stalled edge leaves both outputs as they were
    a_hold_on_stall : assert property (@(posedge clk) disable iff (!rst_n)
        !ena |=> ($stable(magnitude) && $stable(overflow)))
        else begin
            $error("magnitude or overflow changed after an edge with ena low");
            fail_count++;
        end

    // Saturation always goes with the flag
    a_flag_saturates : assert property (@(posedge clk)
        overflow |-> (magnitude == 8'hff))
        else begin
            $error("overflow set while magnitude is not 255");
            fail_count++;
        end

    a_reset_zero : assert property (@(posedge clk)
        !rst_n |-> (magnitude == 8'd0 && !overflow))  // Async clear already done
        else begin
            $error("outputs not zero while reset is asserted");
            fail_count++;
        end

endmodule

// Attach to every result stage
bind magnitude_result mag_asserts u_mag_asserts (
    .clk       (clk),
    .rst_n     (rst_n),
    .ena       (ena),
    .magnitude (magnitude),
    .overflow  (overflow)
);

// ==== verification/mag_checker.sv ====
module mag_checker #(
    parameter int LATENCY = 12                 // Enabled edges from pins to pins
) (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       ena,
    input  logic [7:0] ui_in,                  // x as driven
    input  logic [7:0] uio_in,                 // y as driven
    input  logic [7:0] uo_out,
    input  logic [7:0] uio_out,
    input  logic [7:0] uio_oe,
    output int         error_count,
    output int         check_count
);
    timeunit 1ns;
    timeprecision 1ps;

    // Expected pin values for one vector
    typedef struct packed {
        logic [7:0] mag;    // Saturated root
        logic       over;   // Root above 255
    } expect_t;

    expect_t     history [$];  // One entry per enabled edge with the oldest first
    expect_t     expected;
    logic        seen_enabled; // Any enabled edge since reset
    logic        prev_valid;
    logic        prev_ena;
    logic [15:0] prev_pins;    // {uo_out, uio_out} at the previous edge
    int          errors = 0;
    int          checks = 0;

    assign error_count = errors;
    assign check_count = checks;

    // Floor square root by plain search and clamp to the pin width
    function automatic expect_t model(input logic [7:0] x, input logic [7:0] y);
        int      sum;
        int      root;
        expect_t res;
        sum  = int'(x) * int'(x) + int'(y) * int'(y);
        root = 0;
        for (int r = 1; r * r <= sum; r++) begin
            root = r;
        end
        res.over = (root > 255);
        res.mag  = res.over ? 8'd255 : root[7:0];
        return res;
    endfunction

    task automatic flag_error(input string msg);
        $display("[ERROR] %0d ns: %s", $time, msg);
        errors++;
    endtask

    // Samples before the DUT's own updates at this edge
    always @(posedge clk) begin
        if (!rst_n) begin
            history.delete();
            repeat (LATENCY) history.push_back(model(8'd0, 8'd0));  // Pipeline of zero vectors
            seen_enabled = 1'b0;
            prev_valid   = 1'b0;
        end else begin
            checks++;
            if (uio_oe !== 8'h01)
                flag_error($sformatf("uio_oe expected 01 got %h", uio_oe));
            if (ena) begin
                expected = history.pop_front();  // Vector from LATENCY enabled edges back
                checks++;
                if (uo_out !== expected.mag || uio_out !== {7'b0, expected.over})
                    flag_error($sformatf("expected mag %0d flag %0b, got mag %0d uio_out %h",
                                         expected.mag, expected.over, uo_out, uio_out));
                history.push_back(model(ui_in, uio_in));
                seen_enabled = 1'b1;
            end else if (!seen_enabled) begin
                checks++;  // Still the reset state
                if (uo_out !== 8'd0 || uio_out !== 8'd0)
                    flag_error($sformatf("idle outputs expected 0/0, got %0d/%h",
                                         uo_out, uio_out));
            end
            // Disabled previous edge means nothing may have moved
            if (prev_valid && !prev_ena) begin
                checks++;
                if ({uo_out, uio_out} !== prev_pins)
                    flag_error($sformatf("outputs moved on a disabled edge, %h to %h",
                                         prev_pins, {uo_out, uio_out}));
            end
            prev_pins  = {uo_out, uio_out};
            prev_ena   = ena;
            prev_valid = 1'b1;
        end
    end

endmodule

// ==== verification/tb_top.sv ====
module tb_top;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int          CLK_PERIOD   = 40;
    localparam int          RESET_CYCLES = 3;
    localparam int          LATENCY      = 12;           // Registers from pins to pins
    localparam int          N_CORNER     = 5;
    localparam int          N_RANDOM     = 300;
    localparam int          N_BOUND      = 19;           // 16 sweep + 3 diagonal
    localparam int          STALL_BUDGET = 3 * N_RANDOM; // ena is high about half the time
    localparam int          TOTAL_CYCLES = RESET_CYCLES + 4 + N_CORNER + N_RANDOM
                                         + STALL_BUDGET + N_BOUND + 4 * (LATENCY + 2);
    localparam int          TIMEOUT_NS   = 2 * TOTAL_CYCLES * CLK_PERIOD;
    localparam logic [31:0] LFSR_SEED    = 32'hc19e_5126;
    localparam logic [31:0] LFSR_TAPS    = 32'h8020_0003;  // x^32 + x^22 + x^2 + x + 1

    localparam logic [7:0] CORNER_X [N_CORNER] = '{8'd0, 8'd3, 8'd255, 8'd180, 8'd255};
    localparam logic [7:0] CORNER_Y [N_CORNER] = '{8'd0, 8'd4, 8'd0,   8'd180, 8'd255};

    logic        clk;
    logic        rst_n;
    logic        ena;
    logic [7:0]  ui_in;
    logic [7:0]  uio_in;
    wire  [7:0]  uo_out;
    wire  [7:0]  uio_out;
    wire  [7:0]  uio_oe;
    logic [31:0] lfsr_state;
    int          errors;
    int          checks;
    int          errors_mark;
    int          checks_mark;

    tt_um_addon dut (
        .ui_in   (ui_in),
        .uio_in  (uio_in),
        .uo_out  (uo_out),
        .uio_out (uio_out),
        .uio_oe  (uio_oe),
        .ena     (ena),
        .clk     (clk),
        .rst_n   (rst_n)
    );

    mag_checker #(.LATENCY(LATENCY)) u_checker (
        .clk         (clk),
        .rst_n       (rst_n),
        .ena         (ena),
        .ui_in       (ui_in),
        .uio_in      (uio_in),
        .uo_out      (uo_out),
        .uio_out     (uio_out),
        .uio_oe      (uio_oe),
        .error_count (errors),
        .check_count (checks)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    // Right-shifting Galois form
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        if (state[0])
            return (state >> 1) ^ LFSR_TAPS;
        return state >> 1;
    endfunction

    function automatic logic [7:0] rand_bits(input int count);
        logic [7:0] bits;
        bits = '0;
        for (int i = 0; i < count; i++) begin
            lfsr_state = lfsr_next(lfsr_state);  // One step per bit
            bits       = {bits[6:0], lfsr_state[0]};
        end
        return bits;
    endfunction

    task automatic drive(input logic [7:0] x, input logic [7:0] y, input logic en);
        @(posedge clk);
        ui_in  <= x;
        uio_in <= y;
        ena    <= en;
    endtask

    // Zero vectors push the last real one out to the pins
    task automatic flush();
        repeat (LATENCY + 1) drive(8'd0, 8'd0, 1'b1);
        @(negedge clk);
    endtask

    task automatic report_test(input string name);
        $display("%s done: %0d checks, %0d errors", name, checks - checks_mark,
                 errors - errors_mark);
        checks_mark = checks;
        errors_mark = errors;
    endtask

    task automatic run_random(input logic stall);
        int         sent;
        logic [7:0] x;
        logic [7:0] y;
        logic [7:0] en_bits;
        sent = 0;
        while (sent < N_RANDOM) begin
            x       = rand_bits(8);
            y       = rand_bits(8);
            en_bits = stall ? rand_bits(1) : 8'd1;
            drive(x, y, en_bits[0]);               // Stalled vectors are never sampled
            if (en_bits[0])
                sent++;
        end
        flush();
    endtask

    initial begin
        ui_in       = '0;
        uio_in      = '0;
        ena         = 1'b0;
        rst_n       = 1'b1;
        lfsr_state  = LFSR_SEED;
        errors_mark = 0;
        checks_mark = 0;
        #1 rst_n = 1'b0;                           // Clean falling edge for the async clear
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        repeat (3) @(posedge clk);                 // Idle with ena still low
        @(negedge clk);
        report_test("reset_idle");
        for (int i = 0; i < N_CORNER; i++)
            drive(CORNER_X[i], CORNER_Y[i], 1'b1);
        flush();
        report_test("corners");
        run_random(1'b0);
        report_test("random_full");
        run_random(1'b1);
        report_test("random_stall");
        // 255^2 + y^2 crosses 256^2 between y = 22 and y = 23
        for (int y = 16; y < 32; y++)
            drive(8'd255, 8'(y), 1'b1);
        drive(8'd181, 8'd181, 1'b1);               // Root 255
        drive(8'd181, 8'd182, 1'b1);               // Root 256
        drive(8'd182, 8'd181, 1'b1);
        flush();
        report_test("overflow_edge");
        $display("Total: %0d checks, %0d errors, %0d assertion failures", checks, errors,
                 dut.u_result.u_mag_asserts.fail_count);
        if (errors == 0 && dut.u_result.u_mag_asserts.fail_count == 0 && checks > 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #(TIMEOUT_NS);
        $display("Simulation timed out after %0d ns without finishing the tests", TIMEOUT_NS);
        $display("Test failed");
        $finish;
    end

endmodule
